//--- include/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// line geometry in fetch periods of 16 dram cycles each
// one period is 64 clocks of the 28 MHz clock

// periods in one scan line
`define VIDEO_PERIODS_PER_LINE 6

// periods at the start of the line with the graphics window open
// must stay below VIDEO_PERIODS_PER_LINE
`define VIDEO_FETCH_PERIODS 4

// dram words collected per period
// the byte reorder in video_fetch is built for exactly four
`define VIDEO_WORDS_PER_PERIOD 4

`endif

//--- hdl/video_pkg.sv
package video_pkg;

	localparam int dram_word_w = 16; // arbiter data bus
	localparam int pic_word_w  = 64; // four dram words make one picture word
	localparam int pix_index_w = 4;  // colour index out of the shifter

	// pixel format of the shifter
	typedef enum logic
	{
		render_1bpp = 1'b0, // one bit per pixel, 64 pixels per word
		render_4bpp = 1'b1  // one nibble per pixel, held 4 clocks
	} render_mode_t;

	// graphics fetch window state
	typedef enum logic
	{
		win_idle  = 1'b0, // no data wanted this period
		win_fetch = 1'b1  // arbiter may deliver words
	} window_state_t;

endpackage

//--- hdl/dram_strobe_gen.sv
module dram_strobe_gen (
	input  logic clk,
	input  logic rst,
	output logic pre_cend, // phase 2, one clock ahead of cend
	output logic cend      // phase 3, end of a 7 MHz dram cycle
);

	logic [1:0] phase; // position inside the 4 clock dram cycle

	always_ff @(posedge clk)
	begin
		if (rst)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1; // wraps every fourth clock
	end

	// plain decode, low while phase is held at 0 in reset
	assign pre_cend = (phase == 2'd2);
	assign cend     = (phase == 2'd3);

	// cend always preceded by pre_cend
	a_cend_after_pre : assert property (
		@(posedge clk) disable iff (rst)
		cend |-> $past(pre_cend)
	);

endmodule

//--- hdl/fetch_window.sv
`include "video_config.svh"

module fetch_window import video_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic cend,         // dram cycle end strobe
	output logic fetch_gfx,    // graphics window, level
	output logic period_start  // cend that opens a fetch period
);

	localparam int period_w = $clog2(`VIDEO_PERIODS_PER_LINE);

	// window moves on the third cend of the period
	// same cend as ptr_clr in video_fetch, one cend after fetch_sync copied the buffer
	localparam logic [3:0] win_edge = 4'd2;

	logic [3:0]          cend_cnt;   // cends inside the period
	logic [period_w-1:0] period_cnt; // period index inside the line
	window_state_t       state;

	assign period_start = cend && (cend_cnt == 4'd0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cend_cnt   <= 4'd0;
			period_cnt <= '0;
		end
		else if (cend)
		begin
			cend_cnt <= cend_cnt + 4'd1; // 16 cends per period
			if (cend_cnt == 4'hf) // last cend, step to next period
			begin
				if (period_cnt == period_w'(`VIDEO_PERIODS_PER_LINE - 1))
					period_cnt <= '0; // new line
				else
					period_cnt <= period_cnt + 1'b1;
			end
		end
	end

	// window fsm, only moves on the window edge cend
	always_ff @(posedge clk)
	begin
		if (rst)
			state <= win_idle;
		else if (cend && (cend_cnt == win_edge))
		begin
			case (state)
				win_idle:
					if (period_cnt == '0)
						state <= win_fetch; // line starts
				win_fetch:
					if (period_cnt == period_w'(`VIDEO_FETCH_PERIODS))
						state <= win_idle; // window length used up
				default:
					state <= win_idle;
			endcase
		end
	end

	assign fetch_gfx = (state == win_fetch);

	// window level only changes right after a cend
	a_gfx_on_cend : assert property (
		@(posedge clk) disable iff (rst)
		$changed(fetch_gfx) |-> $past(cend)
	);

endmodule

//--- hdl/video_fetch.sv
module video_fetch import video_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cend,         // dram cycle end
	input  logic                   pre_cend,     // one clock before cend
	input  logic                   period_start, // cend opening a period
	input  logic                   fetch_gfx,    // graphics window
	input  logic [dram_word_w-1:0] video_data,   // word from the arbiter
	input  logic                   video_strobe, // video_data valid, one clock
	output logic                   video_go,     // data request to the arbiter
	output logic                   fetch_sync,   // picture word handover
	output logic [pic_word_w-1:0]  pic_bits,     // reordered picture word
	output logic                   pic_valid     // pic_bits came from a full window period
);

	localparam int         words      = pic_word_w / dram_word_w;
	localparam logic [2:0] words_full = 3'(words);

	logic [3:0]             sync_ctr;  // cends since period_start
	logic                   ptr_clr;   // restarts the fill for a new window period
	logic [1:0]             fetch_ptr; // next buffer slot
	logic [2:0]             word_cnt;  // words taken since ptr_clr
	logic                   win_open;  // window seen open since ptr_clr
	logic [dram_word_w-1:0] fetch_data [words];

	// only the graphics window asks for data
	assign video_go = fetch_gfx;

	always_ff @(posedge clk)
	begin
		if (rst)
			sync_ctr <= 4'hf; // keeps sync pulses off until the first period
		else if (cend)
		begin
			if (period_start)
				sync_ctr <= 4'd0;
			else
				sync_ctr <= sync_ctr + 4'd1;
		end
	end

	// both pulses come out of pre_cend, so each sits on a cend
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fetch_sync <= 1'b0;
			ptr_clr    <= 1'b0;
		end
		else
		begin
			fetch_sync <= pre_cend && (sync_ctr == 4'd0); // second cend of the period
			ptr_clr    <= pre_cend && (sync_ctr == 4'd1); // third cend, window moves here
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst || ptr_clr)
		begin
			fetch_ptr <= 2'd0;
			word_cnt  <= 3'd0;
			win_open  <= 1'b0;
		end
		else
		begin
			if (video_strobe)
			begin
				fetch_ptr <= fetch_ptr + 2'd1;
				word_cnt  <= word_cnt + 3'd1;
			end
			if (fetch_gfx)
				win_open <= 1'b1;
		end
	end

	// word buffer
	always_ff @(posedge clk)
	begin
		if (video_strobe)
			fetch_data[fetch_ptr] <= video_data;
	end

	// high byte of word k is picture byte 2k, low byte is 2k+1
	always_ff @(posedge clk)
	begin
		if (fetch_sync)
		begin
			for (int k = 0; k < words; k++)
			begin
				pic_bits[16*k +: 8]     <= fetch_data[k][15:8];
				pic_bits[16*k + 8 +: 8] <= fetch_data[k][7:0];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pic_valid <= 1'b0;
		else if (fetch_sync)
			pic_valid <= win_open && (word_cnt == words_full); // all words in a window period
	end

	// no back-pressure, a fifth word would overwrite slot 0
	a_no_ptr_wrap : assert property (
		@(posedge clk) disable iff (rst)
		video_strobe |-> (word_cnt < words_full)
	);

	// arbiter answers requests only
	a_strobe_in_window : assert property (
		@(posedge clk) disable iff (rst)
		video_strobe |-> video_go
	);

endmodule

//--- hdl/pixel_shifter.sv
module pixel_shifter import video_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  render_mode_t           mode,       // pixel format request
	input  logic                   fetch_sync, // new picture word next clock
	input  logic [pic_word_w-1:0]  pic_bits,
	input  logic                   pic_valid,
	output logic [pix_index_w-1:0] pix_index,  // colour index
	output logic                   pix_valid
);

	logic [pic_word_w-1:0] shift_reg; // pixel 0 sits in the low bits
	logic [5:0]            pix_cnt;   // clock within the 64 clock word
	logic                  run;       // word being shifted out
	logic                  word_ok;   // current word is real picture data
	logic                  load;      // clock after fetch_sync, pic_bits settled
	logic                  step;      // shift this clock
	render_mode_t          mode_next; // mode taken at fetch_sync
	render_mode_t          cur_mode;  // mode of the word being shifted

	// every clock in 1bpp, every fourth clock in 4bpp
	assign step = (cur_mode == render_1bpp) || (pix_cnt[1:0] == 2'b11);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			load      <= 1'b0;
			run       <= 1'b0;
			word_ok   <= 1'b0;
			pix_cnt   <= 6'd0;
			mode_next <= render_1bpp;
			cur_mode  <= render_1bpp;
		end
		else
		begin
			load <= fetch_sync;
			if (fetch_sync)
				mode_next <= mode; // held until the word boundary
			if (load)
			begin
				run      <= 1'b1;
				word_ok  <= pic_valid;
				pix_cnt  <= 6'd0;
				cur_mode <= mode_next;
			end
			else if (run)
			begin
				pix_cnt <= pix_cnt + 6'd1;
				if (pix_cnt == 6'd63)
					run <= 1'b0; // no follow-up word, go idle
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk)
	begin
		if (load)
			shift_reg <= pic_bits;
		else if (run && step)
		begin
			if (cur_mode == render_1bpp)
				shift_reg <= shift_reg >> 1;
			else
				shift_reg <= shift_reg >> 4;
		end
	end

	always_comb
	begin
		if (cur_mode == render_1bpp)
			pix_index = {{(pix_index_w - 1){1'b0}}, shift_reg[0]}; // zero extended bit
		else
			pix_index = shift_reg[pix_index_w-1:0]; // low nibble
	end

	assign pix_valid = run && word_ok;

	// words arrive exactly at the end of the previous one, or into an idle shifter
	a_sync_on_boundary : assert property (
		@(posedge clk) disable iff (rst)
		fetch_sync |=> (!run || (pix_cnt == 6'd63))
	);

endmodule

//--- hdl/video_top.sv
module video_top import video_pkg::*; (
	input  logic                   clk,          // 28 MHz
	input  logic                   rst,
	input  render_mode_t           mode,         // pixel format, used from the next word on
	input  logic [dram_word_w-1:0] video_data,   // arbiter read data
	input  logic                   video_strobe, // one pulse per delivered word
	output logic                   video_go,     // fetch request to the arbiter
	output logic                   cend,         // dram cycle strobes for the arbiter
	output logic                   pre_cend,
	output logic [pix_index_w-1:0] pix_index,
	output logic                   pix_valid
);

	logic                  fetch_gfx;
	logic                  period_start;
	logic                  fetch_sync;
	logic [pic_word_w-1:0] pic_bits;
	logic                  pic_valid;

	// 7 MHz dram cycle strobes
	dram_strobe_gen u_strobe (
		.clk      (clk),
		.rst      (rst),
		.pre_cend (pre_cend),
		.cend     (cend)
	);

	// periods and graphics window
	fetch_window u_window (
		.clk          (clk),
		.rst          (rst),
		.cend         (cend),
		.fetch_gfx    (fetch_gfx),
		.period_start (period_start)
	);

	// word collection and byte reorder
	video_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.cend         (cend),
		.pre_cend     (pre_cend),
		.period_start (period_start),
		.fetch_gfx    (fetch_gfx),
		.video_data   (video_data),
		.video_strobe (video_strobe),
		.video_go     (video_go),
		.fetch_sync   (fetch_sync),
		.pic_bits     (pic_bits),
		.pic_valid    (pic_valid)
	);

	// picture word to colour indices
	pixel_shifter u_shifter (
		.clk        (clk),
		.rst        (rst),
		.mode       (mode),
		.fetch_sync (fetch_sync),
		.pic_bits   (pic_bits),
		.pic_valid  (pic_valid),
		.pix_index  (pix_index),
		.pix_valid  (pix_valid)
	);

endmodule

//--- sim/clock_gen.sv
module clock_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 5;

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// synchronous reset, released on an edge
	initial
	begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- sim/video_tb.sv
`include "video_config.svh"

module video_tb import video_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int cends_per_period = 16;
	localparam int cends_per_line   = cends_per_period * `VIDEO_PERIODS_PER_LINE;
	localparam int pix_per_line     = `VIDEO_FETCH_PERIODS * 64;
	localparam int run_lines        = 5; // two 1bpp, two 4bpp, one 1bpp again
	localparam int line_timeout     = (run_lines + 2) * cends_per_line * 4;

	logic                   clk;
	logic                   rst;
	render_mode_t           mode         = render_1bpp;
	logic [dram_word_w-1:0] video_data   = '0;
	logic                   video_strobe = 1'b0;
	logic                   video_go;
	logic                   cend;
	logic                   pre_cend;
	logic [pix_index_w-1:0] pix_index;
	logic                   pix_valid;

	logic [3:0] exp_q [$];      // expected pixels, oldest first
	int         pix_total    = 0; // valid pixels seen so far
	int         lines_done   = 0; // lines begun after reset
	int         windows_full = 0; // window periods with four words
	int         error_count  = 0;

	// pacing monitor state
	logic pre_seen  = 1'b0;
	logic cend_seen = 1'b0;
	int   clk_gap   = 0;

	clock_gen u_clock (
		.clk (clk),
		.rst (rst)
	);

	video_top DUT (
		.clk          (clk),
		.rst          (rst),
		.mode         (mode),
		.video_data   (video_data),
		.video_strobe (video_strobe),
		.video_go     (video_go),
		.cend         (cend),
		.pre_cend     (pre_cend),
		.pix_index    (pix_index),
		.pix_valid    (pix_valid)
	);

	task automatic fail_stop(input string what);
		error_count++;
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// 4bpp for lines 2 and 3 only
	function automatic render_mode_t line_mode(input int line);
		if (line >= 2 && line < 4)
			return render_4bpp;
		else
			return render_1bpp;
	endfunction

	// 64 pixel indices of one picture, pixel n in bits 4n+3..4n
	function automatic logic [255:0] ref_pixels(input logic [3:0][15:0] words,
		input render_mode_t m);
		logic [63:0]  pic;
		logic [7:0]   pic_byte;
		logic [255:0] pix;
		for (int b = 0; b < 8; b++)
		begin
			if (b % 2 == 0)
				pic_byte = words[b / 2][15:8]; // even byte from the high half
			else
				pic_byte = words[b / 2][7:0];
			for (int i = 0; i < 8; i++)
				pic[8 * b + i] = pic_byte[i];
		end
		for (int n = 0; n < 64; n++)
		begin
			if (m == render_1bpp)
				pix[4 * n +: 4] = {3'b000, pic[n]};
			else
				pix[4 * n +: 4] = pic[4 * (n / 4) +: 4]; // nibble held 4 clocks
		end
		return pix;
	endfunction

	// dram arbiter model, line tracking and window checks
	initial
	begin : arbiter_model
		int               cend_pos;
		int               period;
		int               slot;
		int               sent;
		int               line_num;
		int               pix_mark;
		logic [31:0]      rnd;
		logic [15:0]      word;
		logic [3:0][15:0] words;
		logic [255:0]     pix;
		cend_pos = 0;
		sent     = 0;
		line_num = 0;
		pix_mark = 0;
		words    = '0;
		void'($urandom(67));
		forever
		begin
			@(posedge clk);
			if (rst)
			begin
				cend_pos = 0;
				sent     = 0;
				line_num = 0;
				video_strobe <= 1'b0;
			end
			else
			begin
				video_strobe <= 1'b0;
				if (cend)
				begin
					period = cend_pos / cends_per_period;
					slot   = cend_pos % cends_per_period;
					if (cend_pos == 0) // line boundary
					begin
						if (line_num > 0)
						begin
							assert (pix_total - pix_mark == pix_per_line)
							else fail_stop($sformatf("[FAIL] pix_valid per line: expected 0x%h, got 0x%h",
								pix_per_line, pix_total - pix_mark));
						end
						pix_mark = pix_total;
						mode       <= line_mode(line_num);
						lines_done <= line_num;
					end
					// window moves at the third cend, new words from the fourth on
					if (slot == 3)
					begin
						if (sent != 0)
						begin
							assert (sent == 4)
							else fail_stop($sformatf("[FAIL] words per window period: expected 0x4, got 0x%h",
								sent));
							windows_full <= windows_full + 1;
						end
						sent = 0;
					end
					if (video_go && sent < 4)
					begin
						rnd  = $urandom();
						word = rnd[15:0];
						video_data   <= word;
						video_strobe <= 1'b1;
						words[sent] = word;
						sent++;
						if (sent == 4) // picture complete, queue its pixels
						begin
							pix = ref_pixels(words, mode);
							for (int n = 0; n < 64; n++)
								exp_q.push_back(pix[4 * n +: 4]);
						end
					end
					if (period > `VIDEO_FETCH_PERIODS)
					begin
						assert (video_go == 1'b0)
						else fail_stop($sformatf("[FAIL] video_go: expected 0x0 in idle period, got 0x%h",
							video_go));
					end
					else if (period >= 1 && period < `VIDEO_FETCH_PERIODS)
					begin
						assert (video_go == 1'b1)
						else fail_stop($sformatf("[FAIL] video_go: expected 0x1 in window, got 0x%h",
							video_go));
					end
					cend_pos++;
					if (cend_pos == cends_per_line)
					begin
						cend_pos = 0;
						line_num++;
					end
				end
			end
		end
	end

	// pixel compare
	always @(posedge clk)
	begin : pixel_compare
		logic [3:0] exp_pix;
		if (!rst && pix_valid)
		begin
			assert (exp_q.size() > 0)
			else fail_stop("pix_valid went high before a full window period was fetched");
			exp_pix = exp_q.pop_front();
			assert (pix_index === exp_pix)
			else fail_stop($sformatf("[FAIL] pix_index: expected 0x%h, got 0x%h",
				exp_pix, pix_index));
			pix_total <= pix_total + 1;
		end
	end

	// strobe pacing
	always @(posedge clk)
	begin
		if (rst)
		begin
			pre_seen  = 1'b0;
			cend_seen = 1'b0;
			clk_gap   = 0;
		end
		else
		begin
			clk_gap++;
			if (pre_seen)
			begin
				assert (cend) else fail_stop("pre_cend was not followed by cend on the next clock");
			end
			if (cend)
			begin
				assert (pre_seen) else fail_stop("cend arrived without pre_cend one clock before");
				if (cend_seen)
				begin
					assert (clk_gap == 4)
					else fail_stop($sformatf("[FAIL] cend spacing: expected 0x4, got 0x%h", clk_gap));
				end
				cend_seen = 1'b1;
				clk_gap   = 0;
			end
			pre_seen = pre_cend;
		end
	end

	initial
	begin : main_flow
		int n;
		n = 0;
		while (rst !== 1'b0)
		begin
			@(posedge clk);
			n++;
			assert (n <= 20) else fail_stop("timeout waiting for reset release");
			if (rst && n >= 2) // registers cleared by now
			begin
				assert (video_go == 1'b0)
				else fail_stop($sformatf("[FAIL] video_go: expected 0x0, got 0x%h", video_go));
				assert (cend == 1'b0)
				else fail_stop($sformatf("[FAIL] cend: expected 0x0, got 0x%h", cend));
				assert (pre_cend == 1'b0)
				else fail_stop($sformatf("[FAIL] pre_cend: expected 0x0, got 0x%h", pre_cend));
				assert (pix_valid == 1'b0)
				else fail_stop($sformatf("[FAIL] pix_valid: expected 0x0, got 0x%h", pix_valid));
			end
		end
		n = 0;
		while (lines_done < run_lines)
		begin
			@(posedge clk);
			n++;
			assert (n < line_timeout) else fail_stop("timeout waiting for the video lines to finish");
		end
		assert (exp_q.size() == 0)
		else fail_stop($sformatf("[FAIL] pending pixels: expected 0x0, got 0x%h", exp_q.size()));
		assert (windows_full == run_lines * `VIDEO_FETCH_PERIODS)
		else fail_stop($sformatf("[FAIL] full window periods: expected 0x%h, got 0x%h",
			run_lines * `VIDEO_FETCH_PERIODS, windows_full));
		if (error_count == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			fail_stop("errors were recorded during the run");
		end
	end

endmodule

//--- filelist.f
+incdir+include
hdl/video_pkg.sv
hdl/dram_strobe_gen.sv
hdl/fetch_window.sv
hdl/video_fetch.sv
hdl/pixel_shifter.sv
hdl/video_top.sv
sim/clock_gen.sv
sim/video_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the video fetch testbench with verilator
set -e

cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module video_tb \
	-f filelist.f \
	-o video_sim

./obj_dir/video_sim > "$log" 2>&1 || true
cat "$log"

if grep -q "tests failed" "$log"; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "all tests passed" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation PASSED"
